/* design/mips_pkg.sv */
package mips_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_WORDS  = 64;
    localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);

    // All ones word stops the core
    localparam logic [XLEN-1:0] HALT_WORD = 32'hFFFF_FFFF;

    //////////////////////////////
    // Opcode and funct codes
    //////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_SLTI  = 6'b001010;

    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLL  = 6'b000000;

    // ALU operations, NONE means no register write
    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_NOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_NONE = 4'd15;

    // Wishbone word address, region in the top two bits
    localparam int WB_ADR_W = 10;
    localparam logic [1:0] REGION_IMEM = 2'b00;
    localparam logic [1:0] REGION_REGS = 2'b01;
    localparam logic [1:0] REGION_CTRL = 2'b10;

    // One instruction word seen as R-type or I-type fields
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
    } instr_word_u;

endpackage

/* design/id_ex_if.sv */
`timescale 1ns/1ps

interface id_ex_if
    import mips_pkg::*;
();

    logic                  valid;
    logic [ALU_OP_W-1:0]   alu_op;
    // Forwarding tags for op_a and op_b, zero means no forward
    logic [REG_ADDR_W-1:0] rs_idx;
    logic [REG_ADDR_W-1:0] rt_idx;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [REG_ADDR_W-1:0] dest;
    // Halt token travels down the pipe like an instruction
    logic                  halt;

    modport decode (
        output valid, alu_op, rs_idx, rt_idx, op_a, op_b, dest, halt
    );

    modport execute (
        input  valid, alu_op, rs_idx, rt_idx, op_a, op_b, dest, halt
    );

endinterface

/* design/instr_mem.sv */
`timescale 1ns/1ps

module instr_mem
    import mips_pkg::*;
(
    input  logic                   clk,
    input  logic [XLEN-1:0]        pc,
    output instr_word_u            instr,
    input  logic                   imem_we,
    input  logic [IMEM_ADDR_W-1:0] imem_waddr,
    input  logic [XLEN-1:0]        imem_wdata
);

    // Word storage, filled by the host
    logic [XLEN-1:0] mem [IMEM_WORDS];

    // PC is a byte address, words step by 4
    logic [IMEM_ADDR_W-1:0] rd_addr;

    assign rd_addr = pc[IMEM_ADDR_W+1:2];

    //////////////////////////////
    // Host write port
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (imem_we)
        begin
            mem[imem_waddr] <= imem_wdata;
        end
    end

    // Registered read, word shows up one cycle after pc
    always_ff @(posedge clk)
    begin
        instr <= mem[rd_addr];
    end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage
    import mips_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic            halt_seen,
    output logic [XLEN-1:0] pc,
    output logic            fetch_valid
);

    // Set by start, dropped once decode reports the halt word
    logic running;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc          <= '0;
            running     <= 1'b0;
            fetch_valid <= 1'b0;
        end
        else
        begin
            // Lines up with the registered read in instr_mem
            fetch_valid <= running;

            if (start)
            begin
                // Program always begins at word 0
                pc      <= '0;
                running <= 1'b1;
            end
            else if (halt_seen)
            begin
                running <= 1'b0;
            end
            else if (running)
            begin
                pc <= pc + XLEN'(4);
            end
        end
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  fetch_valid,
    input  instr_word_u           instr,
    output logic [REG_ADDR_W-1:0] ra_idx,
    output logic [REG_ADDR_W-1:0] rb_idx,
    input  logic [XLEN-1:0]       ra_data,
    input  logic [XLEN-1:0]       rb_data,
    output logic                  halt_seen,
    id_ex_if.decode               ex
);

    logic [ALU_OP_W-1:0]   alu_op;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [REG_ADDR_W-1:0] a_tag;
    logic [REG_ADDR_W-1:0] b_tag;
    logic [REG_ADDR_W-1:0] dest;
    logic                  is_halt;
    logic                  take;

    // Register reads straight from the word
    assign ra_idx = instr.r.rs;
    assign rb_idx = instr.r.rt;

    assign is_halt = (instr == HALT_WORD);
    // Words fetched behind the halt are dropped
    assign take    = fetch_valid && !halt_seen;

    //////////////////////////////
    // Operation and operand select
    //////////////////////////////
    always_comb
    begin
        alu_op = ALU_NONE;
        op_a   = ra_data;
        op_b   = rb_data;
        a_tag  = instr.r.rs;
        b_tag  = instr.r.rt;
        dest   = instr.r.rd;
        case (instr.r.opcode)
            OP_RTYPE:
            begin
                case (instr.r.funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB,
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:
                    begin
                        // Shift source is rt and the amount is shamt
                        alu_op = ALU_SLL;
                        op_a   = rb_data;
                        a_tag  = instr.r.rt;
                        op_b   = XLEN'(instr.r.shamt);
                        b_tag  = '0;
                    end
                    default: alu_op = ALU_NONE;
                endcase
            end
            // Immediate forms write rt and never forward operand B
            OP_ADDI, OP_SLTI:
            begin
                alu_op = (instr.i.opcode == OP_ADDI) ? ALU_ADD : ALU_SLT;
                op_b   = {{(XLEN-16){instr.i.imm16[15]}}, instr.i.imm16};
                b_tag  = '0;
                dest   = instr.i.rt;
            end
            OP_ORI:
            begin
                alu_op = ALU_OR;
                op_b   = {{(XLEN-16){1'b0}}, instr.i.imm16};
                b_tag  = '0;
                dest   = instr.i.rt;
            end
            default: alu_op = ALU_NONE;
        endcase
    end

    //////////////////////////////
    // id_ex register and halt detect
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex.valid  <= 1'b0;
            halt_seen <= 1'b0;
        end
        else
        begin
            ex.valid <= take;
            if (start)
                halt_seen <= 1'b0;
            else if (take && is_halt)
                halt_seen <= 1'b1;
        end
        // Payload is only meaningful with valid
        ex.alu_op <= alu_op;
        ex.rs_idx <= a_tag;
        ex.rt_idx <= b_tag;
        ex.op_a   <= op_a;
        ex.op_b   <= op_b;
        ex.dest   <= dest;
        ex.halt   <= is_halt;
    end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    id_ex_if.execute              ex,
    output logic                  wr_en,
    output logic [REG_ADDR_W-1:0] wr_idx,
    output logic [XLEN-1:0]       wr_data,
    output logic                  halted
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;
    logic            fwd_ok;

    //////////////////////////////
    // Forwarding from the result register
    //////////////////////////////
    // Zero tags never match, r0 stays zero
    assign fwd_ok = wr_en && (wr_idx != '0);
    assign a = (fwd_ok && ex.rs_idx == wr_idx) ? wr_data : ex.op_a;
    // Decode zeroes the B tag for immediates and shifts
    assign b = (fwd_ok && ex.rt_idx == wr_idx) ? wr_data : ex.op_b;

    // ALU
    always_comb
    begin
        case (ex.alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_NOR: result = ~(a | b);
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = XLEN'($signed(a) < $signed(b));
            ALU_SLL: result = a << b[4:0];
            default: result = '0;
        endcase
    end

    //////////////////////////////
    // Result register and halted flag
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_en  <= 1'b0;
            halted <= 1'b0;
        end
        else
        begin
            wr_en <= ex.valid && (ex.alu_op != ALU_NONE);
            // Halt token leaving id_ex, older writes land on the same edge
            if (start)
                halted <= 1'b0;
            else if (ex.valid && ex.halt)
                halted <= 1'b1;
        end
        wr_idx  <= ex.dest;
        wr_data <= result;
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] ra_idx,
    input  logic [REG_ADDR_W-1:0] rb_idx,
    output logic [XLEN-1:0]       ra_data,
    output logic [XLEN-1:0]       rb_data,
    input  logic                  wr_en,
    input  logic [REG_ADDR_W-1:0] wr_idx,
    input  logic [XLEN-1:0]       wr_data,
    input  logic [REG_ADDR_W-1:0] host_raddr,
    output logic [XLEN-1:0]       host_rdata
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wr_live;

    // r0 is never written, so it reads zero after reset
    assign wr_live = wr_en && (wr_idx != '0);

    // Same cycle write shows through to the core ports
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
        logic hit;
        hit = wr_live && (wr_idx == idx);
        return hit ? wr_data : regs[idx];
    endfunction

    assign ra_data    = read_port(ra_idx);
    assign rb_data    = read_port(rb_idx);
    // Host only reads a halted core
    assign host_rdata = regs[host_raddr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int k = 0; k < 2**REG_ADDR_W; k++)
                regs[k] <= '0;
        end
        else if (wr_live)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

/* design/wb_host_port.sv */
`timescale 1ns/1ps

module wb_host_port
    import mips_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [WB_ADR_W-1:0]    wb_adr,
    input  logic [XLEN-1:0]        wb_dat_w,
    output logic [XLEN-1:0]        wb_dat_r,
    output logic                   wb_ack,
    output logic                   imem_we,
    output logic [IMEM_ADDR_W-1:0] imem_waddr,
    output logic [XLEN-1:0]        imem_wdata,
    output logic [REG_ADDR_W-1:0]  host_raddr,
    input  logic [XLEN-1:0]        host_rdata,
    input  logic                   halted,
    output logic                   start
);

    logic [1:0] region;
    logic       wr_cycle;

    // Top two address bits pick the region
    assign region   = wb_adr[WB_ADR_W-1 -: 2];
    // Writes take effect on the ack cycle only
    assign wr_cycle = wb_ack && wb_we;

    //////////////////////////////
    // Single cycle ack
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end

    // Memory load and start pulse
    assign imem_we    = wr_cycle && (region == REGION_IMEM);
    assign imem_waddr = wb_adr[IMEM_ADDR_W-1:0];
    assign imem_wdata = wb_dat_w;
    assign start      = wr_cycle && (region == REGION_CTRL);

    // Read mux, sampled by the master while ack is high
    assign host_raddr = wb_adr[REG_ADDR_W-1:0];
    always_comb
    begin
        case (region)
            REGION_REGS: wb_dat_r = host_rdata;
            REGION_CTRL: wb_dat_r = {{(XLEN-1){1'b0}}, halted};
            default:     wb_dat_r = '0;
        endcase
    end

endmodule

/* design/mips_core_top.sv */
`timescale 1ns/1ps

module mips_core_top
    import mips_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [XLEN-1:0]     wb_dat_w,
    output logic [XLEN-1:0]     wb_dat_r,
    output logic                wb_ack,
    output logic                halted
);

    // Host side
    logic                   imem_we;
    logic [IMEM_ADDR_W-1:0] imem_waddr;
    logic [XLEN-1:0]        imem_wdata;
    logic [REG_ADDR_W-1:0]  host_raddr;
    logic [XLEN-1:0]        host_rdata;
    logic                   start;

    // Fetch and decode
    logic [XLEN-1:0]        pc;
    logic                   fetch_valid;
    logic                   halt_seen;
    instr_word_u            instr;

    // Register file ports
    logic [REG_ADDR_W-1:0]  ra_idx;
    logic [REG_ADDR_W-1:0]  rb_idx;
    logic [XLEN-1:0]        ra_data;
    logic [XLEN-1:0]        rb_data;
    logic                   wr_en;
    logic [REG_ADDR_W-1:0]  wr_idx;
    logic [XLEN-1:0]        wr_data;

    id_ex_if u_id_ex ();

    //////////////////////////////
    // Host port and storage
    //////////////////////////////
    wb_host_port u_wb_host_port (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .imem_we, .imem_waddr, .imem_wdata, .host_raddr, .host_rdata, .halted, .start
    );

    instr_mem u_instr_mem (
        .clk, .pc, .instr, .imem_we, .imem_waddr, .imem_wdata
    );

    reg_file u_reg_file (
        .clk, .reset, .ra_idx, .rb_idx, .ra_data, .rb_data,
        .wr_en, .wr_idx, .wr_data, .host_raddr, .host_rdata
    );

    //////////////////////////////
    // Pipeline
    //////////////////////////////
    fetch_stage u_fetch_stage (
        .clk, .reset, .start, .halt_seen, .pc, .fetch_valid
    );

    decode_stage u_decode_stage (
        .clk, .reset, .start, .fetch_valid, .instr,
        .ra_idx, .rb_idx, .ra_data, .rb_data, .halt_seen,
        .ex (u_id_ex.decode)
    );

    execute_stage u_execute_stage (
        .clk, .reset, .start,
        .ex (u_id_ex.execute),
        .wr_en, .wr_idx, .wr_data, .halted
    );

endmodule

/* bench/mips_core_sva.sv */
`timescale 1ns/1ps

module mips_core_sva
(
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic halted,
    input logic start
);

    //////////////////////////////
    // Wishbone handshake
    //////////////////////////////
    // Ack answers a strobe seen on the previous edge
    ack_follows_strobe: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack raised without cyc and stb on the previous cycle");

    // Exactly one ack cycle per transfer
    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held high for two cycles");

    // Halted is sticky until the host writes start
    halted_sticky: assert property (@(posedge clk) disable iff (reset)
        halted && !start |=> halted)
        else $error("halted dropped without a start write");

endmodule

bind mips_core_top mips_core_sva u_mips_core_sva (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_ack, .halted, .start
);

/* bench/mips_core_tb.sv */
`timescale 1ns/1ps

module mips_core_tb
    import mips_pkg::*;
();

    // Ack wait in clocks, status polls before giving up
    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 100;

    logic                clk;
    logic                reset;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [XLEN-1:0]     wb_dat_w;
    logic [XLEN-1:0]     wb_dat_r;
    logic                wb_ack;
    logic                halted;

    // Program table and the register image the ISA model predicts
    logic [XLEN-1:0] prog_word [$];
    string           prog_tag [$];
    logic [XLEN-1:0] model_regs [32];
    integer          seed;

    always #4 clk = ~clk;

    mips_core_top u_mips_core_top (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
        .wb_dat_w, .wb_dat_r, .wb_ack, .halted
    );

    task automatic stop_with_failure;
        $display("Regression failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    //////////////////////////////
    // Wishbone master
    //////////////////////////////
    task automatic wait_for_ack;
        int n;
        n = 0;
        while (!wb_ack && n < ACK_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack)
        begin
            $display("Timeout: the Wishbone slave never raised ack");
            stop_with_failure();
        end
    endtask

    // One classic cycle, signals held through the ack edge
    task automatic bus_transfer(input logic we, input logic [WB_ADR_W-1:0] adr,
                                input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        wait_for_ack();
        // Read data is valid while ack is high
        rdata = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    //////////////////////////////
    // Encoders and ISA model
    //////////////////////////////
    function automatic logic [XLEN-1:0] rtype(input logic [5:0] fn, input int rd,
                                              input int rs, input int rt, input int sh);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [XLEN-1:0] itype(input logic [5:0] op, input int rt,
                                              input int rs, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic add_instr(input string tag, input logic [XLEN-1:0] word);
        prog_tag.push_back(tag);
        prog_word.push_back(word);
    endtask

    // Sequential semantics, one word at a time
    task automatic model_step(input logic [XLEN-1:0] w);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] sext;
        logic [XLEN-1:0] res;
        logic [4:0]      dst;
        logic            wr;
        a    = model_regs[w[25:21]];
        b    = model_regs[w[20:16]];
        sext = {{16{w[15]}}, w[15:0]};
        dst  = w[15:11];
        wr   = 1'b1;
        res  = '0;
        case (w[31:26])
            OP_RTYPE:
            begin
                case (w[5:0])
                    FN_ADD:          res = a + b;
                    FN_SUB, FN_SUBU: res = a - b;
                    FN_AND:          res = a & b;
                    FN_OR:           res = a | b;
                    FN_NOR:          res = ~(a | b);
                    FN_XOR:          res = a ^ b;
                    FN_SLT:          res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:          res = b << w[10:6];
                    default:         wr = 1'b0;
                endcase
            end
            OP_ADDI:
            begin
                dst = w[20:16];
                res = a + sext;
            end
            OP_SLTI:
            begin
                dst = w[20:16];
                res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            end
            OP_ORI:
            begin
                dst = w[20:16];
                res = a | {16'h0000, w[15:0]};
            end
            default: wr = 1'b0;
        endcase
        // r0 is hardwired
        if (wr && dst != 5'd0)
            model_regs[dst] = res;
    endtask

    //////////////////////////////
    // Program tables
    //////////////////////////////
    task automatic first_program;
        logic [15:0] imm [4];
        for (int k = 0; k < 4; k++)
            imm[k] = 16'($random(seed));
        prog_word.delete();
        prog_tag.delete();
        add_instr("addi r1",   itype(OP_ADDI, 1, 0, imm[0]));
        add_instr("addi r2",   itype(OP_ADDI, 2, 0, imm[1] | 16'h8000));
        add_instr("ori r3",    itype(OP_ORI, 3, 0, 16'hF0F0));
        add_instr("addi r4",   itype(OP_ADDI, 4, 1, imm[2] | 16'h8000));
        add_instr("add r5",    rtype(FN_ADD, 5, 1, 2, 0));
        add_instr("sub r6",    rtype(FN_SUB, 6, 1, 2, 0));
        add_instr("subu r7",   rtype(FN_SUBU, 7, 2, 1, 0));
        add_instr("and r8",    rtype(FN_AND, 8, 1, 3, 0));
        add_instr("or r9",     rtype(FN_OR, 9, 2, 3, 0));
        add_instr("nor r10",   rtype(FN_NOR, 10, 1, 3, 0));
        add_instr("xor r11",   rtype(FN_XOR, 11, 1, 2, 0));
        add_instr("slt r12",   rtype(FN_SLT, 12, 2, 1, 0));
        add_instr("slt r13",   rtype(FN_SLT, 13, 1, 2, 0));
        add_instr("slti r14",  itype(OP_SLTI, 14, 2, imm[3] | 16'h8000));
        add_instr("slti r15",  itype(OP_SLTI, 15, 1, 16'h7FFF));
        add_instr("ori r16",   itype(OP_ORI, 16, 2, imm[3] | 16'h8000));
        // Back to back dependencies
        add_instr("add r18",   rtype(FN_ADD, 18, 1, 2, 0));
        add_instr("add r18",   rtype(FN_ADD, 18, 18, 18, 0));
        add_instr("sub r19",   rtype(FN_SUB, 19, 18, 1, 0));
        add_instr("xor r20",   rtype(FN_XOR, 20, 19, 18, 0));
        // Producer and consumer two slots apart
        add_instr("addi r21",  itype(OP_ADDI, 21, 0, imm[0]));
        add_instr("or r22",    rtype(FN_OR, 22, 3, 3, 0));
        add_instr("and r23",   rtype(FN_AND, 23, 2, 2, 0));
        add_instr("add r24",   rtype(FN_ADD, 24, 21, 21, 0));
        add_instr("addi r0",   itype(OP_ADDI, 0, 0, imm[1]));
        add_instr("add r25",   rtype(FN_ADD, 25, 0, 1, 0));
        add_instr("sll r26",   rtype(FN_SLL, 26, 0, 1, 4));
        add_instr("sll r27",   rtype(FN_SLL, 27, 0, 26, 31));
        add_instr("halt",      HALT_WORD);
        // Fetched behind the halt, never retired
        add_instr("add r28",   rtype(FN_ADD, 28, 1, 2, 0));
        add_instr("addi r29",  itype(OP_ADDI, 29, 0, imm[2]));
    endtask

    task automatic second_program;
        logic [15:0] imm [3];
        for (int k = 0; k < 3; k++)
            imm[k] = 16'($random(seed));
        prog_word.delete();
        prog_tag.delete();
        add_instr("addi r1",   itype(OP_ADDI, 1, 0, imm[0]));
        add_instr("sub r2",    rtype(FN_SUB, 2, 2, 1, 0));
        add_instr("nor r3",    rtype(FN_NOR, 3, 3, 0, 0));
        add_instr("sll r4",    rtype(FN_SLL, 4, 0, 1, 7));
        add_instr("slti r5",   itype(OP_SLTI, 5, 2, imm[1]));
        add_instr("or r30",    rtype(FN_OR, 30, 1, 2, 0));
        add_instr("ori r31",   itype(OP_ORI, 31, 30, imm[2]));
        add_instr("halt",      HALT_WORD);
        add_instr("add r6",    rtype(FN_ADD, 6, 1, 1, 0));
        add_instr("addi r7",   itype(OP_ADDI, 7, 0, 16'h0001));
    endtask

    //////////////////////////////
    // Run and check
    //////////////////////////////
    task automatic wait_for_halt;
        logic [XLEN-1:0] status;
        int              polls;
        status = '0;
        polls  = 0;
        while (!status[0] && polls < POLL_LIMIT)
        begin
            bus_transfer(1'b0, {REGION_CTRL, 8'd0}, '0, status);
            polls++;
        end
        if (!status[0])
        begin
            $display("Timeout: the core never reported halted in the status register");
            stop_with_failure();
        end
    endtask

    task automatic check_registers;
        logic [XLEN-1:0] rdata;
        for (int k = 0; k < 32; k++)
        begin
            bus_transfer(1'b0, {REGION_REGS, 8'(k)}, '0, rdata);
            assert (rdata === model_regs[k])
            else
            begin
                $display("ERROR wb_dat_r r%0d: got 0x%08h expected 0x%08h",
                         k, rdata, model_regs[k]);
                stop_with_failure();
            end
        end
    endtask

    task automatic run_table;
        logic [XLEN-1:0] rdata;
        int              idx;
        for (int i = 0; i < prog_word.size(); i++)
        begin
            $display("imem[%0d] %s 0x%08h", i, prog_tag[i], prog_word[i]);
            bus_transfer(1'b1, {REGION_IMEM, 8'(i)}, prog_word[i], rdata);
        end
        // Model stops at the halt word like the core
        idx = 0;
        while (idx < prog_word.size() && prog_word[idx] != HALT_WORD)
        begin
            model_step(prog_word[idx]);
            idx++;
        end
        bus_transfer(1'b1, {REGION_CTRL, 8'd0}, '0, rdata);
        wait_for_halt();
        assert (halted === 1'b1)
        else
        begin
            $display("ERROR halted: got 0x%0h expected 0x1", halted);
            stop_with_failure();
        end
        check_registers();
    endtask

    initial
    begin
        clk      = 1'b0;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        seed     = 93;
        for (int k = 0; k < 32; k++)
            model_regs[k] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        first_program();
        run_table();
        // Registers carry over into the second run
        second_program();
        run_table();

        $display("Regression passed");
        $finish;
    end

endmodule

/* project.f */
design/mips_pkg.sv
design/id_ex_if.sv
design/instr_mem.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/reg_file.sv
design/wb_host_port.sv
design/mips_core_top.sv
bench/mips_core_sva.sv
bench/mips_core_tb.sv
